// File: src/ctr_pkg.sv
// Shared definitions for the MMIO counter block
//  bus widths, data-memory request and response structs
//  MMIO offset union, slice strobes, counter indices and slot decode
package ctr_pkg;

  // Bus and counter sizes
  // ----------------------------------------------------------
  localparam int ADDR_W    = 32;                // Data-memory address width
  localparam int DATA_W    = 32;                // Data-memory word width
  localparam int STRB_W    = DATA_W / 8;        // One strobe per byte
  localparam int OFF_W     = 5;                 // Byte offset inside MMIO window
  localparam int NUM_CTRS  = 3;                 // Counter slices
  localparam int CTR_IDX_W = $clog2(NUM_CTRS);  // Slice index width

  localparam int CTR_TIME    = 0;  // Slice index and inhibit bit of time
  localparam int CTR_CYCLE   = 1;  // Slice index and inhibit bit of cycle
  localparam int CTR_INSTRET = 2;  // Slice index and inhibit bit of instret

  // MMIO window slots, 8 bytes each
  localparam logic [1:0] SLOT_MTIME    = 2'd0;
  localparam logic [1:0] SLOT_MTIMECMP = 2'd1;  // Not a slice
  localparam logic [1:0] SLOT_CYCLE    = 2'd2;
  localparam logic [1:0] SLOT_INSTRET  = 2'd3;

  typedef logic [63:0] ctr_val_t;  // One counter value

  // Bus types
  // ----------------------------------------------------------
  typedef struct packed {
    logic              req;    // Single cycle request strobe
    logic              wen;    // Write enable
    logic [ADDR_W-1:0] addr;   // Byte address
    logic [STRB_W-1:0] strb;   // Write byte strobes
    logic [DATA_W-1:0] wdata;  // Write data
  } dmem_req_t;

  typedef struct packed {
    logic              gnt;    // Response valid
    logic              err;    // Access error
    logic [DATA_W-1:0] rdata;  // Read data
  } dmem_rsp_t;

  // Window offset, byte address or slot/half/byte fields
  typedef union packed {
    logic [OFF_W-1:0] raw;
    struct packed {
      logic [1:0] slot;      // Register pair
      logic       hi;        // Upper word of the pair
      logic [1:0] byte_sel;  // Byte within the word
    } f;
  } mmio_off_u;

  typedef struct packed {
    logic              req;    // Window hit strobe
    logic              wen;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] wdata;
    mmio_off_u         off;    // Offset into the window
  } mmio_req_t;

  typedef struct packed {
    logic wr_lo;  // Load bits 31:0
    logic wr_hi;  // Load bits 63:32
    logic inc;    // Count up by one
  } ctr_wr_t;

  // Slot decode shared by the write and read paths
  // ----------------------------------------------------------
  function automatic logic slot_is_ctr(input logic [1:0] slot);
    return slot != SLOT_MTIMECMP;
  endfunction

  function automatic logic [CTR_IDX_W-1:0] slot_to_ctr(input logic [1:0] slot);
    logic [CTR_IDX_W-1:0] idx;
    case (slot)
      SLOT_MTIME:   idx = CTR_IDX_W'(CTR_TIME);
      SLOT_CYCLE:   idx = CTR_IDX_W'(CTR_CYCLE);
      SLOT_INSTRET: idx = CTR_IDX_W'(CTR_INSTRET);
      default:      idx = '0;  // mtimecmp, caller checks slot_is_ctr
    endcase
    return idx;
  endfunction

endpackage

// File: src/ctr_slice.sv
`timescale 1ns/1ps
// One 64-bit counter slice
//  half-word loads with priority over the increment
module ctr_slice (
  input  logic                       g_clk,   // Global clock
  input  logic                       rst,     // Sync reset, active high
  input  ctr_pkg::ctr_wr_t           ctr_wr,  // Write and increment strobes
  input  logic [ctr_pkg::DATA_W-1:0] wdata,   // MMIO write word
  output ctr_pkg::ctr_val_t          value    // Current count
);

  localparam int HW = ctr_pkg::DATA_W;  // Half width

  // Counter register
  // ----------------------------------------------------------
  always_ff @(posedge g_clk) begin
    if (rst) begin
      value <= '0;
    end else if (ctr_wr.wr_lo) begin
      value[HW-1:0] <= wdata;           // Upper half kept
    end else if (ctr_wr.wr_hi) begin
      value[2*HW-1:HW] <= wdata;        // Lower half kept
    end else if (ctr_wr.inc) begin
      value <= value + 64'd1;
    end
  end

endmodule

// File: src/ctr_ctrl.sv
`timescale 1ns/1ps
// Counter control
//  time prescaler and delayed instret pulse
//  per-slice half-word write strobes and gated increment enables
module ctr_ctrl #(
  parameter int unsigned TIME_DIV = 4  // Cycles per time tick
) (
  input  logic                                  g_clk,      // Global clock
  input  logic                                  rst,        // Sync reset, active high
  input  ctr_pkg::mmio_req_t                    mmio_req,   // Window access
  input  logic                                  instr_ret,  // Instruction retired pulse
  input  logic [ctr_pkg::NUM_CTRS-1:0]          inhibit,    // Per counter stop
  output ctr_pkg::ctr_wr_t [ctr_pkg::NUM_CTRS-1:0] ctr_wr   // Slice strobes
);

  localparam int PRE_W = (TIME_DIV > 1) ? $clog2(TIME_DIV) : 1;

  if (TIME_DIV < 1) begin : g_bad_div
    $error("TIME_DIV must be at least 1");
  end

  // Time prescaler
  // ----------------------------------------------------------
  logic [PRE_W-1:0] pre_cnt;  // Cycles left to next tick
  logic             tm_tick;  // Time advances this cycle
  logic             ret_q;    // instr_ret one cycle late

  assign tm_tick = pre_cnt == '0;

  always_ff @(posedge g_clk) begin
    if (rst) begin
      pre_cnt <= PRE_W'(TIME_DIV - 1);
      ret_q   <= 1'b0;
    end else begin
      pre_cnt <= tm_tick ? PRE_W'(TIME_DIV - 1) : pre_cnt - 1'b1;  // Reload on tick
      ret_q   <= instr_ret;
    end
  end

  // Every tick has a tick exactly TIME_DIV cycles before it
  a_tick_period: assert property (@(posedge g_clk) disable iff (rst)
    tm_tick && !$past(rst, TIME_DIV) |-> $past(tm_tick, TIME_DIV));

  // Write and increment decode
  // ----------------------------------------------------------
  logic                         wr_ok;    // Full word write into the window
  logic                         wr_ctr;   // Target slot is a slice
  logic [ctr_pkg::NUM_CTRS-1:0] inc_src;  // Raw increment per slice

  assign wr_ok  = mmio_req.req && mmio_req.wen && (mmio_req.strb == '1);  // Partial refused
  assign wr_ctr = ctr_pkg::slot_is_ctr(mmio_req.off.f.slot);

  always_comb begin
    inc_src                       = '0;
    inc_src[ctr_pkg::CTR_TIME]    = tm_tick;
    inc_src[ctr_pkg::CTR_CYCLE]   = 1'b1;   // Free running
    inc_src[ctr_pkg::CTR_INSTRET] = ret_q;
  end

  for (genvar i = 0; i < ctr_pkg::NUM_CTRS; i++) begin : g_wr
    logic sel;  // This slice addressed

    assign sel = wr_ok && wr_ctr &&
                 (ctr_pkg::slot_to_ctr(mmio_req.off.f.slot) == ctr_pkg::CTR_IDX_W'(i));

    assign ctr_wr[i].wr_lo = sel && !mmio_req.off.f.hi;
    assign ctr_wr[i].wr_hi = sel &&  mmio_req.off.f.hi;
    assign ctr_wr[i].inc   = inc_src[i] && !inhibit[i];  // Gated by inhibit
  end

endmodule

// File: src/ctr_readback.sv
`timescale 1ns/1ps
// Counter readback
//  mtimecmp register and its half-word writes
//  read mux, registered MMIO response and timer interrupt flag
module ctr_readback (
  input  logic                                     g_clk,           // Global clock
  input  logic                                     rst,             // Sync reset, active high
  input  ctr_pkg::mmio_req_t                       mmio_req,        // Window access
  input  ctr_pkg::ctr_val_t [ctr_pkg::NUM_CTRS-1:0] values,         // Slice counts
  output ctr_pkg::dmem_rsp_t                       mmio_rsp,        // One cycle later
  output logic                                     timer_interrupt  // mtime >= mtimecmp
);

  localparam int HW = ctr_pkg::DATA_W;

  // Access decode
  // ----------------------------------------------------------
  logic full_strb;  // All byte lanes set
  logic cmp_wr;     // Full word write to mtimecmp
  logic bad_wr;     // Partial strobe write

  assign full_strb = mmio_req.strb == '1;
  assign cmp_wr    = mmio_req.req && mmio_req.wen && full_strb &&
                     (mmio_req.off.f.slot == ctr_pkg::SLOT_MTIMECMP);
  assign bad_wr    = mmio_req.req && mmio_req.wen && !full_strb;

  // Compare register
  // ----------------------------------------------------------
  ctr_pkg::ctr_val_t mtimecmp;

  always_ff @(posedge g_clk) begin
    if (rst) begin
      mtimecmp <= '1;  // No interrupt until set
    end else if (cmp_wr && !mmio_req.off.f.hi) begin
      mtimecmp[HW-1:0] <= mmio_req.wdata;
    end else if (cmp_wr) begin
      mtimecmp[2*HW-1:HW] <= mmio_req.wdata;
    end
  end

  // Read mux
  // ----------------------------------------------------------
  ctr_pkg::ctr_val_t rd_val;   // Addressed register pair
  logic [HW-1:0]     rd_word;  // Addressed half

  always_comb begin
    if (ctr_pkg::slot_is_ctr(mmio_req.off.f.slot)) begin
      rd_val = values[ctr_pkg::slot_to_ctr(mmio_req.off.f.slot)];
    end else begin
      rd_val = mtimecmp;
    end
  end

  assign rd_word = mmio_req.off.f.hi ? rd_val[2*HW-1:HW] : rd_val[HW-1:0];

  // Response and interrupt registers
  // ----------------------------------------------------------
  logic          gnt_q;    // Grant, one cycle after req
  logic          err_q;    // Refused write
  logic [HW-1:0] rdata_q;  // Captured read word

  always_ff @(posedge g_clk) begin
    if (rst) begin
      gnt_q           <= 1'b0;
      err_q           <= 1'b0;
      timer_interrupt <= 1'b0;
    end else begin
      gnt_q           <= mmio_req.req;
      err_q           <= bad_wr;
      timer_interrupt <= values[ctr_pkg::CTR_TIME] >= mtimecmp;  // Level, registered
    end
  end

  always_ff @(posedge g_clk) begin
    if (mmio_req.req && !mmio_req.wen) begin
      rdata_q <= rd_word;  // Only reads load data
    end
  end

  assign mmio_rsp = '{gnt: gnt_q, err: err_q, rdata: rdata_q};

  // Requester waits for the grant before the next window access
  a_one_outstanding: assert property (@(posedge g_clk) disable iff (rst)
    mmio_req.req |=> !mmio_req.req);

endmodule

// File: src/core_mmio_mux.sv
`timescale 1ns/1ps
// Data-memory MMIO mux
//  window hit decode, steering of requests to the external bus
//  or the counter block, and merge of the two response paths
module core_mmio_mux #(
  parameter logic [ctr_pkg::ADDR_W-1:0] MMIO_BASE_ADDR = 32'h0000_1000, // Window base
  parameter logic [ctr_pkg::ADDR_W-1:0] MMIO_BASE_MASK = 32'hFFFF_FFE0  // Window mask
) (
  input  ctr_pkg::dmem_req_t int_dmem_req,  // From the load/store unit
  output ctr_pkg::dmem_rsp_t int_dmem_rsp,  // Back to the load/store unit
  output ctr_pkg::dmem_req_t ext_dmem_req,  // External data bus request
  input  ctr_pkg::dmem_rsp_t ext_dmem_rsp,  // External data bus response
  output ctr_pkg::mmio_req_t mmio_req,      // To counter control and readback
  input  ctr_pkg::dmem_rsp_t mmio_rsp       // Registered counter response
);

  // Window must span the whole offset field
  if (MMIO_BASE_MASK[ctr_pkg::OFF_W-1:0] != '0) begin : g_bad_mask
    $error("MMIO mask does not clear the window offset bits");
  end

  // Window decode
  // ----------------------------------------------------------
  logic win_hit;  // Address falls in the counter window

  assign win_hit = (int_dmem_req.addr & MMIO_BASE_MASK) == MMIO_BASE_ADDR;

  // Request steering
  // ----------------------------------------------------------
  always_comb begin
    ext_dmem_req     = int_dmem_req;                   // Zero latency copy
    ext_dmem_req.req = int_dmem_req.req && !win_hit;   // Held off on a hit
  end

  always_comb begin
    mmio_req.req     = int_dmem_req.req && win_hit;
    mmio_req.wen     = int_dmem_req.wen;
    mmio_req.strb    = int_dmem_req.strb;
    mmio_req.wdata   = int_dmem_req.wdata;
    mmio_req.off.raw = int_dmem_req.addr[ctr_pkg::OFF_W-1:0];  // Byte offset
  end

  // Response merge
  // ----------------------------------------------------------
  // Counter block owns the bus only in its grant cycle
  assign int_dmem_rsp = mmio_rsp.gnt ? mmio_rsp : ext_dmem_rsp;

  // One outstanding request, so only one side may answer
  always_comb begin : chk_gnt_excl
    assert final (!(mmio_rsp.gnt && ext_dmem_rsp.gnt))
      else $error("MMIO and external grant in the same cycle");
  end

endmodule

// File: src/ctr_mmio_top.sv
`timescale 1ns/1ps
// MMIO counter top level
//  data-memory mux, counter control, counter slices and readback
module ctr_mmio_top #(
  parameter logic [ctr_pkg::ADDR_W-1:0] MMIO_BASE_ADDR = 32'h0000_1000, // Window base
  parameter logic [ctr_pkg::ADDR_W-1:0] MMIO_BASE_MASK = 32'hFFFF_FFE0, // Window mask
  parameter int unsigned                TIME_DIV       = 4              // Time prescale
) (
  input  logic                         g_clk,           // Global clock
  input  logic                         rst,             // Sync reset, active high
  input  ctr_pkg::dmem_req_t           int_dmem_req,    // Load/store request
  output ctr_pkg::dmem_rsp_t           int_dmem_rsp,    // Load/store response
  output ctr_pkg::dmem_req_t           ext_dmem_req,    // External data bus request
  input  ctr_pkg::dmem_rsp_t           ext_dmem_rsp,    // External data bus response
  input  logic                         instr_ret,       // Instruction retired
  input  logic [ctr_pkg::NUM_CTRS-1:0] inhibit,         // Counter stop bits
  output logic                         timer_interrupt  // Raise a timer interrupt
);

  // Internal wiring
  // ----------------------------------------------------------
  ctr_pkg::mmio_req_t                        mmio_req;  // Window access
  ctr_pkg::dmem_rsp_t                        mmio_rsp;  // Counter response
  ctr_pkg::ctr_wr_t  [ctr_pkg::NUM_CTRS-1:0] ctr_wr;    // Slice strobes
  ctr_pkg::ctr_val_t [ctr_pkg::NUM_CTRS-1:0] values;    // Slice counts

  // Submodule instances
  // ----------------------------------------------------------
  core_mmio_mux #(
    .MMIO_BASE_ADDR (MMIO_BASE_ADDR),
    .MMIO_BASE_MASK (MMIO_BASE_MASK)
  ) i_core_mmio_mux (
    .int_dmem_req (int_dmem_req), // From the load/store unit
    .int_dmem_rsp (int_dmem_rsp), // Merged response
    .ext_dmem_req (ext_dmem_req), // Outside the window
    .ext_dmem_rsp (ext_dmem_rsp), // External memory answer
    .mmio_req     (mmio_req    ), // Inside the window
    .mmio_rsp     (mmio_rsp    )  // Counter block answer
  );

  ctr_ctrl #(
    .TIME_DIV (TIME_DIV)
  ) i_ctr_ctrl (
    .g_clk     (g_clk    ),
    .rst       (rst      ),
    .mmio_req  (mmio_req ), // Write decode
    .instr_ret (instr_ret), // Retire pulse
    .inhibit   (inhibit  ), // Increment gates
    .ctr_wr    (ctr_wr   )  // One set per slice
  );

  for (genvar i = 0; i < ctr_pkg::NUM_CTRS; i++) begin : g_ctr
    ctr_slice i_ctr_slice (
      .g_clk  (g_clk         ),
      .rst    (rst           ),
      .ctr_wr (ctr_wr[i]     ), // Strobes for this slice
      .wdata  (mmio_req.wdata), // Shared write word
      .value  (values[i]     )  // Count out
    );
  end

  ctr_readback i_ctr_readback (
    .g_clk           (g_clk          ),
    .rst             (rst            ),
    .mmio_req        (mmio_req       ), // Read select and mtimecmp writes
    .values          (values         ), // All slice counts
    .mmio_rsp        (mmio_rsp       ), // Registered response
    .timer_interrupt (timer_interrupt)  // Compare flag
  );

endmodule

// File: dv/tb_ctr_mmio.sv
`timescale 1ns/1ps
// Testbench for the MMIO counter top level
//  stimulus table, external memory model, compare tasks
//  cycle counter timeout and per-test reporting
module tb_ctr_mmio;

  localparam logic [31:0] WIN_BASE = 32'h0000_1000;  // Default window base
  localparam logic [31:0] WIN_MASK = 32'hFFFF_FFE0;  // Default window mask

  localparam logic [2:0] OP_EXT   = 3'd0;  // External read, write, read back
  localparam logic [2:0] OP_WR    = 3'd1;  // MMIO write, exp is err
  localparam logic [2:0] OP_RD    = 3'd2;  // MMIO read, exp is rdata
  localparam logic [2:0] OP_DELTA = 3'd3;  // Two reads wdata cycles apart, exp is diff
  localparam logic [2:0] OP_RET   = 3'd4;  // wdata instr_ret pulses
  localparam logic [2:0] OP_IRQ   = 3'd5;  // Poll mtime against compare value exp

  typedef struct packed {
    logic [2:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [2:0]  inhib;  // Inhibit level during the test
    logic [31:0] exp;
  } test_t;

  // DUT signals
  // ----------------------------------------------------------
  logic               g_clk;
  logic               rst;
  ctr_pkg::dmem_req_t int_dmem_req;
  ctr_pkg::dmem_rsp_t int_dmem_rsp;
  ctr_pkg::dmem_req_t ext_dmem_req;
  ctr_pkg::dmem_rsp_t ext_dmem_rsp;
  logic               instr_ret;
  logic [2:0]         inhibit;
  logic               timer_interrupt;

  test_t       tests[$];           // Stimulus table
  int          err_count   = 0;    // Failed checks
  int          cycle_count = 0;
  int          cycle_limit = 0;    // 0 until the table is built
  logic [31:0] lcg_state   = 32'd62;
  logic [31:0] ext_mem [logic [31:0]];  // Written words of the external memory

  ctr_mmio_top UUT (
    .g_clk           (g_clk          ),
    .rst             (rst            ),
    .int_dmem_req    (int_dmem_req   ),
    .int_dmem_rsp    (int_dmem_rsp   ),
    .ext_dmem_req    (ext_dmem_req   ),
    .ext_dmem_rsp    (ext_dmem_rsp   ),
    .instr_ret       (instr_ret      ),
    .inhibit         (inhibit        ),
    .timer_interrupt (timer_interrupt)
  );

  always #10 g_clk = ~g_clk;  // 20 ns period

  always @(posedge g_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: run did not end within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  // External memory model
  // ----------------------------------------------------------
  function automatic logic [31:0] mem_fill(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'hC3A5_0F69;  // Unwritten word pattern
  endfunction

  always @(posedge g_clk) begin
    if (rst) begin
      ext_dmem_rsp <= '0;
    end else begin
      ext_dmem_rsp.gnt <= ext_dmem_req.req;  // Grant one cycle after req
      ext_dmem_rsp.err <= 1'b0;
      if (ext_dmem_req.req && ext_dmem_req.wen) begin
        ext_mem[ext_dmem_req.addr] = ext_dmem_req.wdata;
        ext_dmem_rsp.rdata <= '0;
      end else if (ext_dmem_req.req) begin
        ext_dmem_rsp.rdata <= ext_mem.exists(ext_dmem_req.addr) ?
                              ext_mem[ext_dmem_req.addr] : mem_fill(ext_dmem_req.addr);
      end
    end
  end

  // Helpers and checks
  // ----------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic ctr_pkg::dmem_req_t make_req(input logic [31:0] addr, input logic wen,
                                                  input logic [3:0] strb,
                                                  input logic [31:0] wdata);
    ctr_pkg::dmem_req_t r;
    r.req   = 1'b1;
    r.wen   = wen;
    r.addr  = addr;
    r.strb  = strb;
    r.wdata = wdata;
    return r;
  endfunction

  function automatic ctr_pkg::dmem_rsp_t read_rsp(input logic [31:0] rdata);
    ctr_pkg::dmem_rsp_t r;
    r.gnt   = 1'b1;
    r.err   = 1'b0;
    r.rdata = rdata;
    return r;
  endfunction

  task automatic check_rsp(input string name, input ctr_pkg::dmem_rsp_t got,
                           input ctr_pkg::dmem_rsp_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_req(input string name, input ctr_pkg::dmem_req_t got,
                           input ctr_pkg::dmem_req_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic add_test(input logic [2:0] op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          input logic [2:0] inhib, input logic [31:0] exp);
    test_t t;
    t = '{op: op, addr: addr, wdata: wdata, strb: strb, inhib: inhib, exp: exp};
    tests.push_back(t);
  endtask

  // One access, req in cycle N and response sampled mid N+1
  task automatic do_access(input ctr_pkg::dmem_req_t rq, input logic ext,
                           output ctr_pkg::dmem_rsp_t rsp, output logic irq);
    @(posedge g_clk);
    int_dmem_req <= rq;
    @(negedge g_clk);
    if (ext) check_req("ext_dmem_req", ext_dmem_req, rq);  // Same cycle copy
    else check_word("ext_dmem_req.req", 32'(ext_dmem_req.req), 32'd0);
    check_word("int_dmem_rsp.gnt in req cycle", 32'(int_dmem_rsp.gnt), 32'd0);
    @(posedge g_clk);
    int_dmem_req <= '0;
    @(negedge g_clk);
    rsp = int_dmem_rsp;
    irq = timer_interrupt;
  endtask

  task automatic ext_test();
    ctr_pkg::dmem_rsp_t rsp;
    logic               irq;
    logic [31:0]        addr;
    logic [31:0]        data;
    addr = lcg_next() & 32'hFFFF_FFFC;
    if ((addr & WIN_MASK) == WIN_BASE) addr = addr ^ 32'h8000_0000;  // Keep out of window
    data = lcg_next();
    do_access(make_req(addr, 1'b0, 4'hF, 32'd0), 1'b1, rsp, irq);
    check_rsp("int_dmem_rsp", rsp, read_rsp(mem_fill(addr)));
    do_access(make_req(addr, 1'b1, 4'hF, data), 1'b1, rsp, irq);
    check_rsp("int_dmem_rsp", rsp, read_rsp(32'd0));  // Model returns 0 on writes
    do_access(make_req(addr, 1'b0, 4'hF, 32'd0), 1'b1, rsp, irq);
    check_rsp("int_dmem_rsp", rsp, read_rsp(data));
  endtask

  task automatic delta_test(input test_t t);
    ctr_pkg::dmem_rsp_t rsp_a;
    ctr_pkg::dmem_rsp_t rsp_b;
    logic               irq;
    do_access(make_req(t.addr, 1'b0, 4'hF, 32'd0), 1'b0, rsp_a, irq);
    repeat (int'(t.wdata) - 2) @(posedge g_clk);  // Second req wdata cycles after first
    do_access(make_req(t.addr, 1'b0, 4'hF, 32'd0), 1'b0, rsp_b, irq);
    check_word("int_dmem_rsp.gnt", 32'(rsp_a.gnt & rsp_b.gnt), 32'd1);
    check_word("int_dmem_rsp.err", 32'(rsp_a.err | rsp_b.err), 32'd0);
    check_word("counter delta", rsp_b.rdata - rsp_a.rdata, t.exp);
  endtask

  task automatic timer_poll(input test_t t);
    ctr_pkg::dmem_rsp_t rsp;
    logic               irq;
    logic               seen_lo;
    logic               seen_hi;
    int                 polls;
    seen_lo = 1'b0;
    seen_hi = 1'b0;
    polls   = 0;
    while (!seen_hi && polls < 200) begin
      do_access(make_req(t.addr, 1'b0, 4'hF, 32'd0), 1'b0, rsp, irq);
      polls++;
      check_word("int_dmem_rsp.gnt", 32'(rsp.gnt), 32'd1);
      check_word("timer_interrupt", 32'(irq), 32'(rsp.rdata >= t.exp));  // Rises at compare
      if (rsp.rdata >= t.exp) seen_hi = 1'b1;
      else seen_lo = 1'b1;
    end
    if (!seen_hi) begin
      $display("mtime never reached the compare value while polling");
      err_count++;
    end
    if (!seen_lo) begin
      $display("mtime was already at the compare value on the first read");
      err_count++;
    end
  endtask

  function automatic string op_name(input logic [2:0] op);
    case (op)
      OP_EXT:   return "external";
      OP_WR:    return "mmio write";
      OP_RD:    return "mmio read";
      OP_DELTA: return "counter delta";
      OP_RET:   return "instret pulses";
      default:  return "timer interrupt";
    endcase
  endfunction

  // Stimulus table and main loop
  // ----------------------------------------------------------
  initial begin
    ctr_pkg::dmem_rsp_t rsp;
    logic               irq;
    int                 errs_before;
    int                 n_pass;
    int                 n_fail;
    g_clk        = 1'b0;
    rst          = 1'b1;
    int_dmem_req = '0;
    ext_dmem_rsp = '0;
    instr_ret    = 1'b0;
    inhibit      = '0;
    n_pass       = 0;
    n_fail       = 0;

    add_test(OP_RD,    32'h1008, 32'd0,         4'hF,    3'b000, 32'hFFFF_FFFF);
    add_test(OP_RD,    32'h100C, 32'd0,         4'hF,    3'b000, 32'hFFFF_FFFF);
    add_test(OP_EXT,   32'd0,    32'd0,         4'hF,    3'b000, 32'd0);
    add_test(OP_EXT,   32'd0,    32'd0,         4'hF,    3'b000, 32'd0);
    add_test(OP_WR,    32'h1008, 32'h1234_5678, 4'hF,    3'b000, 32'd0);
    add_test(OP_WR,    32'h100C, 32'h9ABC_DEF0, 4'hF,    3'b000, 32'd0);
    add_test(OP_RD,    32'h1008, 32'd0,         4'hF,    3'b000, 32'h1234_5678);
    add_test(OP_RD,    32'h100C, 32'd0,         4'hF,    3'b000, 32'h9ABC_DEF0);
    add_test(OP_WR,    32'h1008, 32'hDEAD_BEEF, 4'b0011, 3'b000, 32'd1);  // Partial
    add_test(OP_RD,    32'h1008, 32'd0,         4'hF,    3'b000, 32'h1234_5678);
    add_test(OP_WR,    32'h100C, 32'h0BAD_F00D, 4'b1110, 3'b000, 32'd1);
    add_test(OP_RD,    32'h100C, 32'd0,         4'hF,    3'b000, 32'h9ABC_DEF0);
    add_test(OP_DELTA, 32'h1010, 32'd7,         4'hF,    3'b000, 32'd7);
    add_test(OP_DELTA, 32'h1010, 32'd12,        4'hF,    3'b000, 32'd12);
    add_test(OP_DELTA, 32'h1010, 32'd9,         4'hF,    3'b010, 32'd0);  // Cycle stopped
    add_test(OP_RD,    32'h1014, 32'd0,         4'hF,    3'b000, 32'd0);
    add_test(OP_WR,    32'h1018, 32'd0,         4'hF,    3'b000, 32'd0);
    add_test(OP_RET,   32'd0,    32'd5,         4'hF,    3'b000, 32'd0);
    add_test(OP_RD,    32'h1018, 32'd0,         4'hF,    3'b000, 32'd5);
    add_test(OP_RET,   32'd0,    32'd3,         4'hF,    3'b100, 32'd0);  // Instret stopped
    add_test(OP_RD,    32'h1018, 32'd0,         4'hF,    3'b000, 32'd5);
    add_test(OP_WR,    32'h1000, 32'd0,         4'hF,    3'b000, 32'd0);  // mtime = 0
    add_test(OP_WR,    32'h1004, 32'd0,         4'hF,    3'b000, 32'd0);
    add_test(OP_WR,    32'h100C, 32'd0,         4'hF,    3'b000, 32'd0);
    add_test(OP_WR,    32'h1008, 32'd40,        4'hF,    3'b000, 32'd0);  // mtimecmp = 40
    add_test(OP_IRQ,   32'h1000, 32'd0,         4'hF,    3'b000, 32'd40);
    add_test(OP_EXT,   32'd0,    32'd0,         4'hF,    3'b000, 32'd0);
    cycle_limit = tests.size() * 40 + 200;

    repeat (2) @(posedge g_clk);
    rst <= 1'b0;
    @(negedge g_clk);
    errs_before = err_count;  // Reset state of the outputs
    check_word("int_dmem_rsp.gnt", 32'(int_dmem_rsp.gnt), 32'd0);
    check_word("int_dmem_rsp.err", 32'(int_dmem_rsp.err), 32'd0);
    check_word("timer_interrupt", 32'(timer_interrupt), 32'd0);
    check_word("ext_dmem_req.req", 32'(ext_dmem_req.req), 32'd0);
    $display("test reset state %s", (err_count == errs_before) ? "ok" : "FAILED");
    if (err_count == errs_before) n_pass++;
    else n_fail++;

    foreach (tests[i]) begin
      errs_before = err_count;
      @(posedge g_clk);
      inhibit <= tests[i].inhib;
      case (tests[i].op)
        OP_EXT: ext_test();
        OP_WR: begin
          do_access(make_req(tests[i].addr, 1'b1, tests[i].strb, tests[i].wdata), 1'b0,
                    rsp, irq);
          check_word("int_dmem_rsp.gnt", 32'(rsp.gnt), 32'd1);
          check_word("int_dmem_rsp.err", 32'(rsp.err), tests[i].exp);
        end
        OP_RD: begin
          do_access(make_req(tests[i].addr, 1'b0, 4'hF, 32'd0), 1'b0, rsp, irq);
          check_rsp("int_dmem_rsp", rsp, read_rsp(tests[i].exp));
        end
        OP_DELTA: delta_test(tests[i]);
        OP_RET: begin
          repeat (int'(tests[i].wdata)) begin
            @(posedge g_clk);
            instr_ret <= 1'b1;  // One cycle pulse
            @(posedge g_clk);
            instr_ret <= 1'b0;
          end
        end
        default: timer_poll(tests[i]);
      endcase
      $display("test %0d %s at %h %s", i, op_name(tests[i].op), tests[i].addr,
               (err_count == errs_before) ? "ok" : "FAILED");
      if (err_count == errs_before) n_pass++;
      else n_fail++;
    end

    $display("tests run %0d passed %0d failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (err_count == 0 && n_fail == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
src/ctr_pkg.sv
src/ctr_slice.sv
src/ctr_ctrl.sv
src/ctr_readback.sv
src/core_mmio_mux.sv
src/ctr_mmio_top.sv
dv/tb_ctr_mmio.sv

// File: Bender.yml
package:
  name: ctr_mmio

sources:
  - src/ctr_pkg.sv
  - src/ctr_slice.sv
  - src/ctr_ctrl.sv
  - src/ctr_readback.sv
  - src/core_mmio_mux.sv
  - src/ctr_mmio_top.sv
  - target: test
    files:
      - dv/tb_ctr_mmio.sv
